/* tests/nic_trace.txt */
# op and hex args: W addr data, R addr expected, P data, B count, D count
# H holds rpc_out_ready low, I idles cycles, C reads a counter id against the model
R 0000 1000010000000000
R 0002 8796a5b4c3d2e1f0
R 0004 0f1e2d3c4b5a6978
R 0020 0
W 0008 1
R 000a 2a01
P 00000000deadbeef
W 0006 1
R 000a 2a03
P 0123456789abcdef
P fedcba9876543210
D 2
H
B 5
R 000a 2a0f
D 4
C 0
C 1
C 2
C 7
W 0008 1
R 000a 2a03
C 0
P 0000000000000077
I 8c
R 000c 0
B 96
R 000c 40
C 2

/* vlog.f */
hw/nic_pkg.sv
hw/rpc_fifo_channel.sv
hw/rps_meter.sv
hw/nic_counters.sv
hw/nic_csr.sv
hw/nic_top.sv
tests/nic_props.sv
tests/nic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the NIC testbench with Verilator
set -e
set -o pipefail

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module nic_tb -o nic_sim
./obj_dir/nic_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0

/* tests/nic_tb.sv */
// Trace-driven testbench for the NIC control plane
// Clock and reset, MMIO and RPC drivers, software FIFO model,
// pop monitor, timeout and error summary

`timescale 1ns/1ps

module nic_tb
    import nic_pkg::*;
();

    localparam logic [7:0]   NIC_ID        = 8'h2a;
    localparam logic [127:0] AFU_ID        = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0;
    localparam int           FIFO_LDEPTH   = 2;
    localparam int           FIFO_DEPTH    = 4;
    localparam int           RPS_WINDOW    = 64;
    localparam int           CYCLES_PER_OP = 100;

    logic                   ccip_clk;
    logic                   reset;
    logic                   mmio_wr_valid;
    logic                   mmio_rd_valid;
    logic [mmio_addr_w-1:0] mmio_addr;
    logic [mmio_tid_w-1:0]  mmio_tid;
    logic [mmio_data_w-1:0] mmio_wr_data;
    logic                   mmio_rd_resp_valid;
    logic [mmio_tid_w-1:0]  mmio_rd_resp_tid;
    logic [mmio_data_w-1:0] mmio_rd_resp_data;
    logic                   rpc_in_valid;
    logic [63:0]            rpc_in_data;
    logic                   rpc_out_valid;
    logic [63:0]            rpc_out_data;
    logic                   rpc_out_ready;

    // FIFO model and event totals
    logic [63:0]     model_q [$];
    logic            ready_lvl    = 1'b0;
    logic            start_m      = 1'b0;
    logic            init_m       = 1'b0;
    logic            push_pending = 1'b0;
    int              accepted_m   = 0;
    int              popped_m     = 0;
    int              dropped_m    = 0;
    int              errors       = 0;
    int              cycles       = 0;
    int              cycle_limit  = 1000;
    logic [31:0]     rng_state    = 32'h17ad_245a;
    logic [8:0]      tid          = 9'd0;
    string           trace_q [$];

    initial ccip_clk = 1'b0;
    always #2 ccip_clk = ~ccip_clk;

    nic_top #(
        .NIC_ID      (NIC_ID),
        .AFU_ID      (AFU_ID),
        .RPC_W       (64),
        .FIFO_LDEPTH (FIFO_LDEPTH),
        .RPS_WINDOW  (RPS_WINDOW)
    ) u_dut (
        .ccip_clk           (ccip_clk),
        .reset              (reset),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_addr          (mmio_addr),
        .mmio_tid           (mmio_tid),
        .mmio_wr_data       (mmio_wr_data),
        .mmio_rd_resp_valid (mmio_rd_resp_valid),
        .mmio_rd_resp_tid   (mmio_rd_resp_tid),
        .mmio_rd_resp_data  (mmio_rd_resp_data),
        .rpc_in_valid       (rpc_in_valid),
        .rpc_in_data        (rpc_in_data),
        .rpc_out_valid      (rpc_out_valid),
        .rpc_out_data       (rpc_out_data),
        .rpc_out_ready      (rpc_out_ready)
    );

    // ==============================
    // Timeout and pop monitor
    // ==============================
    always @(posedge ccip_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the trace did not complete", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Pops compared with the oldest modelled word
    always @(posedge ccip_clk) begin
        // Valid follows the model, minus a word pushed for this edge
        if (!reset && rpc_out_valid !== (model_q.size() > int'(push_pending))) begin
            $display("[ERROR] rpc_out_valid got %h expected %h",
                     rpc_out_valid, model_q.size() > int'(push_pending));
            errors++;
        end
        if (!reset && rpc_out_valid && rpc_out_ready) begin
            if (model_q.size() == 0) begin
                $display("A word was popped while the FIFO model was empty");
                errors++;
            end else begin
                if (rpc_out_data !== model_q[0]) begin
                    $display("[ERROR] rpc_out_data got %h expected %h",
                             rpc_out_data, model_q[0]);
                    errors++;
                end
                void'(model_q.pop_front());
                popped_m++;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ==============================
    // Drivers, one operation each
    // ==============================
    task automatic idle_inputs();
        mmio_wr_valid = 1'b0;
        mmio_rd_valid = 1'b0;
        rpc_in_valid  = 1'b0;
        rpc_out_ready = ready_lvl;
        push_pending  = 1'b0;
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        @(negedge ccip_clk);
        idle_inputs();
        mmio_wr_valid = 1'b1;
        mmio_addr     = addr;
        mmio_wr_data  = data;
        if (addr == addr_nic_start) begin
            start_m = data[0];
        end
        if (addr == addr_nic_init) begin
            init_m     = 1'b1;
            accepted_m = 0;
            popped_m   = 0;
            dropped_m  = 0;
            model_q.delete();
        end
        // Extra cycle lets the init strobe finish its clear
        @(negedge ccip_clk);
        idle_inputs();
    endtask

    task automatic mmio_read(input logic [15:0] addr, input logic [63:0] expected);
        int waited;
        @(negedge ccip_clk);
        idle_inputs();
        mmio_rd_valid = 1'b1;
        mmio_addr     = addr;
        mmio_tid      = tid;
        @(negedge ccip_clk);
        idle_inputs();
        waited = 0;
        while (!mmio_rd_resp_valid && waited < 4) begin
            @(negedge ccip_clk);
            waited++;
        end
        if (!mmio_rd_resp_valid) begin
            $display("No read response arrived for address %h", addr);
            errors++;
        end else begin
            if (mmio_rd_resp_tid !== tid) begin
                $display("[ERROR] mmio_rd_resp_tid got %h expected %h", mmio_rd_resp_tid, tid);
                errors++;
            end
            if (mmio_rd_resp_data !== expected) begin
                $display("[ERROR] mmio_rd_resp_data at %h got %h expected %h",
                         addr, mmio_rd_resp_data, expected);
                errors++;
            end
        end
        tid = tid + 9'd1;
    endtask

    // Model decides accept or drop from the state before this edge
    task automatic rpc_push(input logic [63:0] data);
        logic pop_now;
        @(negedge ccip_clk);
        idle_inputs();
        rpc_in_valid = 1'b1;
        rpc_in_data  = data;
        pop_now = (model_q.size() > 0) && ready_lvl;
        if (init_m && start_m) begin
            if (model_q.size() < FIFO_DEPTH || pop_now) begin
                model_q.push_back(data);
                push_pending = 1'b1;
                accepted_m++;
            end else begin
                dropped_m++;
            end
        end
    endtask

    task automatic push_burst(input int count);
        logic [31:0] hi;
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift32(rng_state);
            hi = rng_state;
            rng_state = xorshift32(rng_state);
            rpc_push({hi, rng_state});
        end
    endtask

    task automatic rpc_drain(input int count);
        int target;
        target = popped_m + count;
        ready_lvl = 1'b1;
        while (popped_m < target) begin
            @(negedge ccip_clk);
            idle_inputs();
        end
    endtask

    task automatic hold_ready_low();
        ready_lvl = 1'b0;
        @(negedge ccip_clk);
        idle_inputs();
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(negedge ccip_clk);
            idle_inputs();
        end
    endtask

    task automatic check_counter(input logic [7:0] id);
        logic [63:0] expected;
        case (id)
            cnt_rpc_in:   expected = 64'(accepted_m);
            cnt_rpc_out:  expected = 64'(popped_m);
            cnt_rpc_drop: expected = 64'(dropped_m);
            default:      expected = 64'h0;
        endcase
        mmio_write(addr_get_pck_cnt, {56'h0, id});
        mmio_read(addr_pck_cnt, expected);
    endtask

    // ==============================
    // Trace playback
    // ==============================
    initial begin
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [63:0] arg_a;
        logic [63:0] arg_b;

        reset         = 1'b1;
        mmio_wr_valid = 1'b0;
        mmio_rd_valid = 1'b0;
        mmio_addr     = '0;
        mmio_tid      = '0;
        mmio_wr_data  = '0;
        rpc_in_valid  = 1'b0;
        rpc_in_data   = '0;
        rpc_out_ready = 1'b0;

        fd = $fopen("tests/nic_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tests/nic_trace.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                trace_q.push_back(line);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycle_limit = trace_q.size() * CYCLES_PER_OP;

        repeat (3) @(posedge ccip_clk);
        @(negedge ccip_clk);
        reset = 1'b0;

        foreach (trace_q[i]) begin
            line  = trace_q[i];
            arg_a = '0;
            arg_b = '0;
            op    = line.getc(0);
            n     = $sscanf(line.substr(1, line.len() - 1), "%h %h", arg_a, arg_b);
            case (op)
                "W":     mmio_write(arg_a[15:0], arg_b);
                "R":     mmio_read(arg_a[15:0], arg_b);
                "P":     rpc_push(arg_a);
                "B":     push_burst(int'(arg_a));
                "D":     rpc_drain(int'(arg_a));
                "H":     hold_ready_low();
                "I":     idle_cycles(int'(arg_a));
                "C":     check_counter(arg_a[7:0]);
                default: begin
                    $display("Unknown trace operation in line %0d: %s", i, line);
                    errors++;
                end
            endcase
        end

        idle_cycles(2);
        if (model_q.size() != 0) begin
            $display("FIFO model still holds %0d words after the trace", model_q.size());
            errors++;
        end
        $display("Trace done: %0d operations, %0d errors", trace_q.size(), errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tests/nic_props.sv */
// Concurrent checks on the NIC top level
// MMIO read response timing, RPC output hold and init pulse width

`timescale 1ns/1ps

module nic_props #(
    parameter int RPC_W = 64
) (
    input logic             ccip_clk,
    input logic             reset,
    input logic             mmio_rd_valid,
    input logic             mmio_rd_resp_valid,
    input logic             nic_init,
    input logic             rpc_out_valid,
    input logic             rpc_out_ready,
    input logic [RPC_W-1:0] rpc_out_data
);

    // Every read is answered in the next cycle
    a_rd_resp: assert property (@(posedge ccip_clk) disable iff (reset)
        mmio_rd_valid |=> mmio_rd_resp_valid)
        else $error("read request got no response in the next cycle");

    // Back-pressure holds the oldest word in place
    a_out_hold: assert property (@(posedge ccip_clk) disable iff (reset)
        (rpc_out_valid && !rpc_out_ready) |=> $stable(rpc_out_data))
        else $error("rpc_out_data changed while stalled");

    a_init_pulse: assert property (@(posedge ccip_clk) disable iff (reset)
        nic_init |=> !nic_init)
        else $error("nic_init held for more than one cycle");

endmodule

bind nic_top nic_props #(
    .RPC_W (RPC_W)
) u_props (
    .ccip_clk           (ccip_clk),
    .reset              (reset),
    .mmio_rd_valid      (mmio_rd_valid),
    .mmio_rd_resp_valid (mmio_rd_resp_valid),
    .nic_init           (nic_init),
    .rpc_out_valid      (rpc_out_valid),
    .rpc_out_ready      (rpc_out_ready),
    .rpc_out_data       (rpc_out_data)
);

/* hw/nic_top.sv */
// NIC control plane top level
// Connects the CSR block, RPC FIFO, rate meter and packet counters

`timescale 1ns/1ps

module nic_top
    import nic_pkg::*;
#(
    parameter logic [7:0]   NIC_ID      = 8'h00,
    parameter logic [127:0] AFU_ID      = 128'h0,
    parameter int           RPC_W       = 64,
    parameter int           FIFO_LDEPTH = 3,
    parameter int           RPS_WINDOW  = 200000000
) (
    input  logic                   ccip_clk,
    input  logic                   reset,

    // MMIO
    input  logic                   mmio_wr_valid,
    input  logic                   mmio_rd_valid,
    input  logic [mmio_addr_w-1:0] mmio_addr,
    input  logic [mmio_tid_w-1:0]  mmio_tid,
    input  logic [mmio_data_w-1:0] mmio_wr_data,
    output logic                   mmio_rd_resp_valid,
    output logic [mmio_tid_w-1:0]  mmio_rd_resp_tid,
    output logic [mmio_data_w-1:0] mmio_rd_resp_data,

    // RPC channel
    input  logic                   rpc_in_valid,
    input  logic [RPC_W-1:0]       rpc_in_data,
    output logic                   rpc_out_valid,
    output logic [RPC_W-1:0]       rpc_out_data,
    input  logic                   rpc_out_ready
);

    logic                   nic_start;
    logic                   nic_init;
    logic [cnt_id_w-1:0]    cnt_sel;
    logic                   fifo_ovf;
    logic [rps_w-1:0]       rps_value;
    logic [mmio_data_w-1:0] cnt_value;
    logic                   rpc_accepted;
    logic                   rpc_dropped;
    logic                   rpc_popped;

    assign rpc_popped = rpc_out_valid & rpc_out_ready;

    // ==============================
    // Control plane
    // ==============================
    nic_csr #(
        .NIC_ID (NIC_ID),
        .AFU_ID (AFU_ID)
    ) u_csr (
        .ccip_clk           (ccip_clk),
        .reset              (reset),
        .mmio_wr_valid      (mmio_wr_valid),
        .mmio_rd_valid      (mmio_rd_valid),
        .mmio_addr          (mmio_addr),
        .mmio_tid           (mmio_tid),
        .mmio_wr_data       (mmio_wr_data),
        .mmio_rd_resp_valid (mmio_rd_resp_valid),
        .mmio_rd_resp_tid   (mmio_rd_resp_tid),
        .mmio_rd_resp_data  (mmio_rd_resp_data),
        .nic_start          (nic_start),
        .nic_init           (nic_init),
        .cnt_sel            (cnt_sel),
        .fifo_ovf           (fifo_ovf),
        .rps_value          (rps_value),
        .cnt_value          (cnt_value)
    );

    // ==============================
    // Datapath
    // ==============================
    // FIFO gates start with its own init state, matching the running bit
    rpc_fifo_channel #(
        .RPC_W       (RPC_W),
        .FIFO_LDEPTH (FIFO_LDEPTH)
    ) u_fifo (
        .ccip_clk   (ccip_clk),
        .reset      (reset),
        .clear      (nic_init),
        .running    (nic_start),
        .push_valid (rpc_in_valid),
        .push_data  (rpc_in_data),
        .pop_valid  (rpc_out_valid),
        .pop_data   (rpc_out_data),
        .pop_ready  (rpc_out_ready),
        .accepted   (rpc_accepted),
        .dropped    (rpc_dropped),
        .overflow   (fifo_ovf)
    );

    rps_meter #(
        .RPS_WINDOW (RPS_WINDOW)
    ) u_rps (
        .ccip_clk (ccip_clk),
        .reset    (reset),
        .clear    (nic_init),
        .event_in (rpc_accepted),
        .rate     (rps_value)
    );

    nic_counters u_counters (
        .ccip_clk  (ccip_clk),
        .reset     (reset),
        .clear     (nic_init),
        .rpc_in    (rpc_accepted),
        .rpc_out   (rpc_popped),
        .rpc_drop  (rpc_dropped),
        .cnt_sel   (cnt_sel),
        .cnt_value (cnt_value)
    );

endmodule

/* hw/nic_csr.sv */
// NIC control and status registers
// MMIO write decode for start, init and counter select,
// ready bit, status word and the registered read response

`timescale 1ns/1ps

module nic_csr
    import nic_pkg::*;
#(
    parameter logic [7:0]   NIC_ID = 8'h00,
    parameter logic [127:0] AFU_ID = 128'h0
) (
    input  logic                   ccip_clk,
    input  logic                   reset,

    // MMIO request
    input  logic                   mmio_wr_valid,
    input  logic                   mmio_rd_valid,
    input  logic [mmio_addr_w-1:0] mmio_addr,
    input  logic [mmio_tid_w-1:0]  mmio_tid,
    input  logic [mmio_data_w-1:0] mmio_wr_data,

    // MMIO read response
    output logic                   mmio_rd_resp_valid,
    output logic [mmio_tid_w-1:0]  mmio_rd_resp_tid,
    output logic [mmio_data_w-1:0] mmio_rd_resp_data,

    // Control to the datapath
    output logic                   nic_start,
    output logic                   nic_init,
    output logic [cnt_id_w-1:0]    cnt_sel,

    // Status and counter values
    input  logic                   fifo_ovf,
    input  logic [rps_w-1:0]       rps_value,
    input  logic [mmio_data_w-1:0] cnt_value
);

    logic                   ready;
    logic                   running;
    logic [mmio_data_w-1:0] status_word;
    logic [mmio_data_w-1:0] rd_data;

    // ==============================
    // Write decode
    // ==============================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            nic_start <= 1'b0;
            nic_init  <= 1'b0;
            cnt_sel   <= '0;
            ready     <= 1'b0;
        end else begin
            // Init is a single-cycle strobe
            nic_init <= 1'b0;

            if (mmio_wr_valid) begin
                case (mmio_addr)
                    addr_nic_start:   nic_start <= mmio_wr_data[0];
                    addr_nic_init:    nic_init  <= 1'b1;
                    addr_get_pck_cnt: cnt_sel   <= mmio_wr_data[cnt_id_w-1:0];
                    default: ;
                endcase
            end

            // Datapath is cleared by the init strobe, so it is ready afterwards
            if (nic_init) begin
                ready <= 1'b1;
            end
        end
    end

    // ==============================
    // Status word
    // ==============================
    assign running = ready & nic_start;

    always_comb begin
        status_word                    = '0;
        status_word[stat_ready]        = ready;
        status_word[stat_running]      = running;
        status_word[stat_err_fifo_ovf] = fifo_ovf;
        status_word[stat_error]        = fifo_ovf;
        status_word[stat_nic_id_lsb +: 8] = NIC_ID;
    end

    // ==============================
    // Read path
    // ==============================
    // Write-only and unmapped addresses return zero
    always_comb begin
        case (mmio_addr)
            addr_dfh:        rd_data = dfh_value;
            addr_afu_id_l:   rd_data = AFU_ID[63:0];
            addr_afu_id_h:   rd_data = AFU_ID[127:64];
            addr_nic_status: rd_data = status_word;
            addr_rps:        rd_data = mmio_data_w'(rps_value);
            addr_pck_cnt:    rd_data = cnt_value;
            default:         rd_data = '0;
        endcase
    end

    // Every read is answered in the following cycle
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            mmio_rd_resp_valid <= 1'b0;
        end else begin
            mmio_rd_resp_valid <= mmio_rd_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (mmio_rd_valid) begin
            mmio_rd_resp_tid  <= mmio_tid;
            mmio_rd_resp_data <= rd_data;
        end
    end

endmodule

/* hw/nic_counters.sv */
// Packet counters for accepted, sent and dropped RPCs
// Counter value is selected by counter ID, unknown IDs read zero

`timescale 1ns/1ps

module nic_counters
    import nic_pkg::*;
(
    input  logic                   ccip_clk,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   rpc_in,
    input  logic                   rpc_out,
    input  logic                   rpc_drop,
    input  logic [cnt_id_w-1:0]    cnt_sel,
    output logic [mmio_data_w-1:0] cnt_value
);

    localparam int NUM_CNT = 3;

    logic [mmio_data_w-1:0] cnt [NUM_CNT];
    logic [NUM_CNT-1:0]     strobe;

    // Bit order follows the counter IDs
    assign strobe = {rpc_drop, rpc_out, rpc_in};

    always_ff @(posedge ccip_clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (reset || clear) begin
                cnt[i] <= '0;
            end else if (strobe[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    // Combinational select, the CSR registers it with the read response
    always_comb begin
        case (cnt_sel)
            cnt_rpc_in:   cnt_value = cnt[0];
            cnt_rpc_out:  cnt_value = cnt[1];
            cnt_rpc_drop: cnt_value = cnt[2];
            default:      cnt_value = '0;
        endcase
    end

endmodule

/* hw/rps_meter.sv */
// Request rate meter
// Counts events per fixed window, keeps the last full window's count

`timescale 1ns/1ps

module rps_meter
    import nic_pkg::*;
#(
    parameter int RPS_WINDOW = 200000000
) (
    input  logic             ccip_clk,
    input  logic             reset,
    input  logic             clear,
    input  logic             event_in,
    output logic [rps_w-1:0] rate
);

    logic [rps_w-1:0] win_cnt;
    logic [rps_w-1:0] ev_cnt;
    logic             win_end;

    assign win_end = (win_cnt == rps_w'(RPS_WINDOW - 1));

    always_ff @(posedge ccip_clk) begin
        if (reset || clear) begin
            win_cnt <= '0;
            ev_cnt  <= '0;
            rate    <= '0;
        end else if (win_end) begin
            // Last cycle of the window still counts
            rate    <= ev_cnt + rps_w'(event_in);
            ev_cnt  <= '0;
            win_cnt <= '0;
        end else begin
            ev_cnt  <= ev_cnt + rps_w'(event_in);
            win_cnt <= win_cnt + 1'b1;
        end
    end

endmodule

/* hw/rpc_fifo_channel.sv */
// Synchronous RPC FIFO between host and network side
// Drop-on-full push, ready/valid pop, sticky overflow flag

`timescale 1ns/1ps

module rpc_fifo_channel
    import nic_pkg::*;
#(
    parameter int RPC_W       = mmio_data_w,
    parameter int FIFO_LDEPTH = 3
) (
    input  logic             ccip_clk,
    input  logic             reset,
    input  logic             clear,
    input  logic             running,
    input  logic             push_valid,
    input  logic [RPC_W-1:0] push_data,
    output logic             pop_valid,
    output logic [RPC_W-1:0] pop_data,
    input  logic             pop_ready,
    output logic             accepted,
    output logic             dropped,
    output logic             overflow
);

    localparam int DEPTH = 2 ** FIFO_LDEPTH;

    logic [RPC_W-1:0]       mem [DEPTH];
    logic [FIFO_LDEPTH-1:0] wr_ptr;
    logic [FIFO_LDEPTH-1:0] rd_ptr;
    logic [FIFO_LDEPTH:0]   count;
    logic                   armed;
    logic                   full;
    logic                   pop;
    logic                   admit;

    // Count only reaches its MSB when all DEPTH slots are used
    assign full      = count[FIFO_LDEPTH];
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];
    assign pop       = pop_valid & pop_ready;

    // Channel opens after the first init, and only while started
    assign admit    = push_valid & running & armed & ~clear;
    assign accepted = admit & (~full | pop);
    assign dropped  = admit & full & ~pop;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
            armed    <= 1'b0;
        end else if (clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
            armed    <= 1'b1;
        end else begin
            if (accepted) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({accepted, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // Sticky until the next init
            if (dropped) begin
                overflow <= 1'b1;
            end
        end
    end

    // When full, a push with a pop lands in the slot being freed
    always_ff @(posedge ccip_clk) begin
        if (accepted) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* hw/nic_pkg.sv */
// NIC control plane shared definitions
// MMIO widths and register map, feature header value,
// status word bit positions and packet counter IDs

package nic_pkg;

    // ==============================
    // MMIO widths
    // ==============================
    localparam int mmio_addr_w = 16;
    localparam int mmio_tid_w  = 9;
    localparam int mmio_data_w = 64;

    // Counter select and rate register widths
    localparam int cnt_id_w = 8;
    localparam int rps_w    = 32;

    // ==============================
    // Register map
    // ==============================
    // Word addresses in 32-bit units, 64-bit registers sit on even addresses
    localparam logic [mmio_addr_w-1:0] addr_dfh          = 16'd0;
    localparam logic [mmio_addr_w-1:0] addr_afu_id_l     = 16'd2;
    localparam logic [mmio_addr_w-1:0] addr_afu_id_h     = 16'd4;
    localparam logic [mmio_addr_w-1:0] addr_nic_start    = 16'd6;
    localparam logic [mmio_addr_w-1:0] addr_nic_init     = 16'd8;
    localparam logic [mmio_addr_w-1:0] addr_nic_status   = 16'd10;
    localparam logic [mmio_addr_w-1:0] addr_rps          = 16'd12;
    localparam logic [mmio_addr_w-1:0] addr_get_pck_cnt  = 16'd14;
    localparam logic [mmio_addr_w-1:0] addr_pck_cnt      = 16'd16;

    // Feature type AFU in 63:60, end of feature list at bit 40
    localparam logic [mmio_data_w-1:0] dfh_value = 64'h1000_0100_0000_0000;

    // Status word layout
    localparam int stat_ready        = 0;
    localparam int stat_running      = 1;
    localparam int stat_err_fifo_ovf = 2;
    localparam int stat_error        = 3;
    localparam int stat_nic_id_lsb   = 8;

    // Packet counter IDs
    localparam logic [cnt_id_w-1:0] cnt_rpc_in   = 8'd0;
    localparam logic [cnt_id_w-1:0] cnt_rpc_out  = 8'd1;
    localparam logic [cnt_id_w-1:0] cnt_rpc_drop = 8'd2;

endpackage
